/* all.f */
+incdir+hw
hw/dual_pipe_pkg.sv
hw/wb_if.sv
hw/pipe_stage_regs.sv
hw/mem_result_sel.sv
hw/dual_regfile.sv
hw/pipe_backend_top.sv
tests/pipe_backend_assert.sv
tests/tb_pipe_backend.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_pipe_backend
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_pipe_backend.sv */
module tb_pipe_backend;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 2;
    localparam int RUN_CYCLES      = 2000;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

    // One lane of a stage copy, data is the ALU result in MEM and the write data in WB
    typedef struct packed {
        logic                     we;
        dual_pipe_pkg::reg_addr_t waddr;
        dual_pipe_pkg::word_t     data;
        dual_pipe_pkg::word_t     pc;
    } lane_t;

    logic clk = 1'b0;
    logic rst;
    logic stall_dcache;
    logic stall_div;
    logic flush_csr;
    logic br_a;
    logic exc_a;
    logic exc_b;
    logic ex_we_a;
    logic ex_we_b;
    logic wb_we_a;
    logic wb_we_b;
    dual_pipe_pkg::word_t     ex_pc_a, ex_pc_b, ex_alu_a, ex_alu_b;
    dual_pipe_pkg::dword_t    ex_mul_tmp1, ex_mul_tmp2;
    dual_pipe_pkg::reg_addr_t ex_waddr_a, ex_waddr_b, rd_addr, wb_waddr_a, wb_waddr_b;
    dual_pipe_pkg::wb_sel_t   ex_sel_b;
    dual_pipe_pkg::word_t     rd_data, wb_wdata_a, wb_wdata_b, wb_pc_a, wb_pc_b;

    // Cycle model state
    lane_t                  mem_a, mem_b, wb_a_q, wb_b_q;
    dual_pipe_pkg::dword_t  tmp1_q, tmp2_q;
    dual_pipe_pkg::wb_sel_t sel_q;
    dual_pipe_pkg::word_t   model_regs [32];

    int seed;
    int errors;
    int checks;
    int assert_fails;

    pipe_backend_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    function automatic dual_pipe_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    // Lane B write data, OR of every selected source
    function automatic dual_pipe_pkg::word_t expected_lane_b(
        input dual_pipe_pkg::word_t   alu,
        input dual_pipe_pkg::word_t   pc,
        input dual_pipe_pkg::dword_t  t1,
        input dual_pipe_pkg::dword_t  t2,
        input dual_pipe_pkg::wb_sel_t sel
    );
        dual_pipe_pkg::dword_t prod;
        dual_pipe_pkg::word_t  src [6];
        dual_pipe_pkg::word_t  res;
        prod   = t1 + t2;
        src[0] = alu;
        src[1] = prod[31:0];
        src[2] = prod[63:32];
        src[3] = pc + 32'd4;
        src[4] = {24'h0, alu[7:0]};
        src[5] = {16'h0, alu[15:0]};
        res    = '0;
        for (int i = 0; i < 6; i++) begin
            if (sel[i]) begin
                res = res | src[i];
            end
        end
        return res;
    endfunction

    task automatic drive_inputs(input logic hold_reset);
        logic [31:0] r;
        r            = rand_word();
        rst          = hold_reset;
        stall_dcache = chance(10);
        stall_div    = chance(10);   // About 20% stalled in total
        flush_csr    = chance(3);
        br_a         = chance(15);
        exc_a        = chance(10);
        exc_b        = chance(10);
        ex_pc_a      = rand_word();
        ex_pc_b      = ex_pc_a + 32'd4;
        ex_alu_a     = rand_word();
        ex_alu_b     = rand_word();
        ex_mul_tmp1  = {rand_word(), rand_word()};
        ex_mul_tmp2  = {rand_word(), rand_word()};
        ex_we_a      = chance(85);
        ex_we_b      = chance(85);
        ex_waddr_a   = r[4:0];
        ex_waddr_b   = chance(25) ? r[4:0] : r[9:5];   // Same-address pairs now and then
        rd_addr      = r[19:15];
        ex_sel_b     = 6'b1 << (r[31:20] % 7);          // Shift of 6 leaves an empty select
    endtask

    // Effect of one rising edge on the model
    task automatic step_model();
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (wb_a_q.we && wb_a_q.waddr != '0) begin
                model_regs[wb_a_q.waddr] = wb_a_q.data;
            end
            if (wb_b_q.we && wb_b_q.waddr != '0) begin
                model_regs[wb_b_q.waddr] = wb_b_q.data;   // Younger lane wins
            end
        end
        if (rst || flush_csr) begin
            mem_a  = '0;
            mem_b  = '0;
            wb_a_q = '0;
            wb_b_q = '0;
            tmp1_q = '0;
            tmp2_q = '0;
            sel_q  = '0;
        end else if (!stall_dcache && !stall_div) begin
            wb_a_q      = mem_a;
            wb_a_q.we   = mem_a.we && !exc_a;
            wb_b_q      = mem_b;
            wb_b_q.we   = mem_b.we && !exc_a && !exc_b;
            wb_b_q.data = expected_lane_b(mem_b.data, mem_b.pc, tmp1_q, tmp2_q, sel_q);
            mem_a       = '{ex_we_a, ex_waddr_a, ex_alu_a, ex_pc_a};
            if (br_a) begin
                mem_b  = '{1'b0, ex_waddr_b, 32'h0, 32'h0};
                tmp1_q = '0;
                tmp2_q = '0;
                sel_q  = '0;
            end else begin
                mem_b  = '{ex_we_b, ex_waddr_b, ex_alu_b, ex_pc_b};
                tmp1_q = ex_mul_tmp1;
                tmp2_q = ex_mul_tmp2;
                sel_q  = ex_sel_b;
            end
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_value("wb_we_a", 32'(wb_we_a), 32'(wb_a_q.we));
        check_value("wb_waddr_a", 32'(wb_waddr_a), 32'(wb_a_q.waddr));
        check_value("wb_wdata_a", wb_wdata_a, wb_a_q.data);
        check_value("wb_pc_a", wb_pc_a, wb_a_q.pc);
        check_value("wb_we_b", 32'(wb_we_b), 32'(wb_b_q.we));
        check_value("wb_waddr_b", 32'(wb_waddr_b), 32'(wb_b_q.waddr));
        check_value("wb_wdata_b", wb_wdata_b, wb_b_q.data);
        check_value("wb_pc_b", wb_pc_b, wb_b_q.pc);
        check_value("rd_data", rd_data, model_regs[rd_addr]);
    endtask

    initial begin
        seed   = 32'h4a6a_b5a2;
        errors = 0;
        checks = 0;
        drive_inputs(1'b1);
        step_model();
        for (int cyc = 0; cyc < RESET_CYCLES + RUN_CYCLES; cyc++) begin
            @(negedge clk);
            compare_outputs();
            drive_inputs(cyc < RESET_CYCLES - 1);
            step_model();
        end
        assert_fails = i_dut.i_stage_regs.i_stage_assert.fail_count;
        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the run completed", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tests/pipe_backend_assert.sv */
module pipe_backend_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     flush_csr,
    input logic                     stall_dcache,
    input logic                     stall_div,
    input logic                     br_a,
    input logic                     mem_we_b,
    input logic                     wb_we_a,
    input logic                     wb_we_b,
    input dual_pipe_pkg::reg_addr_t wb_waddr_a,
    input dual_pipe_pkg::reg_addr_t wb_waddr_b,
    input dual_pipe_pkg::word_t     wb_wdata_a,
    input dual_pipe_pkg::word_t     wb_wdata_b,
    input dual_pipe_pkg::word_t     wb_pc_a,
    input dual_pipe_pkg::word_t     wb_pc_b
);
    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;   // Picked up by the testbench at the end
    logic stall;

    assign stall = stall_dcache || stall_div;

    clear_we: assert property (@(posedge clk) (rst || flush_csr) |=> (!wb_we_a && !wb_we_b))
        else begin
            fail_count++;
            $error("Write enables still high after reset or flush");
        end

    // Frozen WB bundle
    stall_hold: assert property (@(posedge clk) (!rst && !flush_csr && stall) |=>
            ($stable(wb_we_a) && $stable(wb_waddr_a) && $stable(wb_wdata_a) && $stable(wb_pc_a)
             && $stable(wb_we_b) && $stable(wb_waddr_b) && $stable(wb_wdata_b)
             && $stable(wb_pc_b)))
        else begin
            fail_count++;
            $error("WB outputs changed during a stall");
        end

    kill_b: assert property (@(posedge clk) (!rst && !flush_csr && !stall && br_a) |=> !mem_we_b)
        else begin
            fail_count++;
            $error("Lane B MEM copy kept its write enable after a branch correction");
        end

endmodule

bind pipe_stage_regs pipe_backend_assert i_stage_assert (
    .clk, .rst, .flush_csr, .stall_dcache, .stall_div, .br_a, .mem_we_b,
    .wb_we_a    (wb_a.we),
    .wb_we_b    (wb_b.we),
    .wb_waddr_a (wb_a.waddr),
    .wb_waddr_b (wb_b.waddr),
    .wb_wdata_a (wb_a.wdata),
    .wb_wdata_b (wb_b.wdata),
    .wb_pc_a    (wb_a.pc),
    .wb_pc_b    (wb_b.pc)
);

/* hw/pipe_backend_top.sv */
module pipe_backend_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall_dcache,
    input  logic                      stall_div,
    input  logic                      flush_csr,
    input  logic                      br_a,
    input  logic                      exc_a,
    input  logic                      exc_b,
    input  dual_pipe_pkg::word_t      ex_pc_a,
    input  dual_pipe_pkg::word_t      ex_pc_b,
    input  dual_pipe_pkg::word_t      ex_alu_a,
    input  dual_pipe_pkg::word_t      ex_alu_b,
    input  dual_pipe_pkg::dword_t     ex_mul_tmp1,
    input  dual_pipe_pkg::dword_t     ex_mul_tmp2,
    input  logic                      ex_we_a,
    input  logic                      ex_we_b,
    input  dual_pipe_pkg::reg_addr_t  ex_waddr_a,
    input  dual_pipe_pkg::reg_addr_t  ex_waddr_b,
    input  dual_pipe_pkg::wb_sel_t    ex_sel_b,
    input  dual_pipe_pkg::reg_addr_t  rd_addr,
    output dual_pipe_pkg::word_t      rd_data,
    output logic                      wb_we_a,
    output dual_pipe_pkg::reg_addr_t  wb_waddr_a,
    output dual_pipe_pkg::word_t      wb_wdata_a,
    output dual_pipe_pkg::word_t      wb_pc_a,
    output logic                      wb_we_b,
    output dual_pipe_pkg::reg_addr_t  wb_waddr_b,
    output dual_pipe_pkg::word_t      wb_wdata_b,
    output dual_pipe_pkg::word_t      wb_pc_b
);

    dual_pipe_pkg::word_t   mem_alu_a;
    dual_pipe_pkg::word_t   mem_alu_b;
    dual_pipe_pkg::word_t   mem_pc_b;
    dual_pipe_pkg::dword_t  mem_mul_tmp1;
    dual_pipe_pkg::dword_t  mem_mul_tmp2;
    dual_pipe_pkg::wb_sel_t mem_sel_b;
    dual_pipe_pkg::word_t   mem_wdata_a;
    dual_pipe_pkg::word_t   mem_wdata_b;

    wb_if wb_a ();
    wb_if wb_b ();

    pipe_stage_regs i_stage_regs (
        .clk, .rst, .stall_dcache, .stall_div, .flush_csr,
        .br_a, .exc_a, .exc_b,
        .ex_pc_a, .ex_pc_b, .ex_alu_a, .ex_alu_b,
        .ex_mul_tmp1, .ex_mul_tmp2,
        .ex_we_a, .ex_we_b, .ex_waddr_a, .ex_waddr_b, .ex_sel_b,
        .mem_alu_a, .mem_alu_b, .mem_pc_b,
        .mem_mul_tmp1, .mem_mul_tmp2, .mem_sel_b,
        .mem_wdata_a, .mem_wdata_b,
        .wb_a (wb_a.producer),
        .wb_b (wb_b.producer)
    );

    // MEM-stage write data, fed back into the WB registers
    mem_result_sel i_result_sel (
        .alu_a    (mem_alu_a),
        .alu_b    (mem_alu_b),
        .pc_b     (mem_pc_b),
        .mul_tmp1 (mem_mul_tmp1),
        .mul_tmp2 (mem_mul_tmp2),
        .sel_b    (mem_sel_b),
        .wdata_a  (mem_wdata_a),
        .wdata_b  (mem_wdata_b)
    );

    dual_regfile i_regfile (
        .clk, .rst,
        .wr_a    (wb_a.consumer),
        .wr_b    (wb_b.consumer),
        .rd_addr,
        .rd_data
    );

    assign wb_we_a    = wb_a.we;
    assign wb_waddr_a = wb_a.waddr;
    assign wb_wdata_a = wb_a.wdata;
    assign wb_pc_a    = wb_a.pc;
    assign wb_we_b    = wb_b.we;
    assign wb_waddr_b = wb_b.waddr;
    assign wb_wdata_b = wb_b.wdata;
    assign wb_pc_b    = wb_b.pc;

endmodule

/* hw/dual_regfile.sv */
`include "dual_pipe_params.svh"

module dual_regfile (
    input  logic                     clk,
    input  logic                     rst,
    wb_if.consumer                   wr_a,     // Older instruction
    wb_if.consumer                   wr_b,     // Younger instruction
    input  dual_pipe_pkg::reg_addr_t rd_addr,
    output dual_pipe_pkg::word_t     rd_data
);

    dual_pipe_pkg::word_t regs [`DP_NREGS];

    logic wen_a;
    logic wen_b;

    // x0 is hardwired, writes to it are dropped
    assign wen_a = wr_a.we && (wr_a.waddr != '0);
    assign wen_b = wr_b.we && (wr_b.waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DP_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen_a) begin
                regs[wr_a.waddr] <= wr_a.wdata;
            end
            // Issued later in the same cycle so lane B overrides on a clash
            if (wen_b) begin
                regs[wr_b.waddr] <= wr_b.wdata;
            end
        end
    end

    // Combinational read
    always_comb begin
        if (rd_addr == '0) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_addr];
        end
    end

endmodule

/* hw/mem_result_sel.sv */
`include "dual_pipe_params.svh"

module mem_result_sel (
    input  dual_pipe_pkg::word_t   alu_a,
    input  dual_pipe_pkg::word_t   alu_b,
    input  dual_pipe_pkg::word_t   pc_b,
    input  dual_pipe_pkg::dword_t  mul_tmp1,   // Multiplier partial products
    input  dual_pipe_pkg::dword_t  mul_tmp2,
    input  dual_pipe_pkg::wb_sel_t sel_b,
    output dual_pipe_pkg::word_t   wdata_a,
    output dual_pipe_pkg::word_t   wdata_b
);

    dual_pipe_pkg::dword_t mul_sum;
    dual_pipe_pkg::word_t  mul_lo;
    dual_pipe_pkg::word_t  mul_hi;
    dual_pipe_pkg::word_t  link_b;
    dual_pipe_pkg::word_t  byte_zx;
    dual_pipe_pkg::word_t  half_zx;

    // Lane A only ever writes back its ALU result
    assign wdata_a = alu_a;

    // Final carry-propagate add of the multiplier
    assign mul_sum = mul_tmp1 + mul_tmp2;
    assign mul_lo  = mul_sum[`DP_XLEN-1:0];
    assign mul_hi  = mul_sum[2*`DP_XLEN-1:`DP_XLEN];

    assign link_b  = pc_b + `DP_XLEN'd4;   // Return address for jal/jalr
    assign byte_zx = {{(`DP_XLEN-8){1'b0}}, alu_b[7:0]};
    assign half_zx = {{(`DP_XLEN-16){1'b0}}, alu_b[15:0]};

    // AND-OR mux where an empty select yields zero
    always_comb begin
        wdata_b = '0;
        if (sel_b[dual_pipe_pkg::SRC_ALU]) begin
            wdata_b = wdata_b | alu_b;
        end
        if (sel_b[dual_pipe_pkg::SRC_MUL_LO]) begin
            wdata_b = wdata_b | mul_lo;
        end
        if (sel_b[dual_pipe_pkg::SRC_MUL_HI]) begin
            wdata_b = wdata_b | mul_hi;
        end
        if (sel_b[dual_pipe_pkg::SRC_LINK]) begin
            wdata_b = wdata_b | link_b;
        end
        if (sel_b[dual_pipe_pkg::SRC_BYTE_ZX]) begin
            wdata_b = wdata_b | byte_zx;
        end
        if (sel_b[dual_pipe_pkg::SRC_HALF_ZX]) begin
            wdata_b = wdata_b | half_zx;
        end
    end

endmodule

/* hw/pipe_stage_regs.sv */
module pipe_stage_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall_dcache,
    input  logic                      stall_div,
    input  logic                      flush_csr,
    input  logic                      br_a,        // Lane A branch correction in EX
    input  logic                      exc_a,       // Exception on MEM-stage lane A
    input  logic                      exc_b,       // Exception on MEM-stage lane B
    input  dual_pipe_pkg::word_t      ex_pc_a,
    input  dual_pipe_pkg::word_t      ex_pc_b,
    input  dual_pipe_pkg::word_t      ex_alu_a,
    input  dual_pipe_pkg::word_t      ex_alu_b,
    input  dual_pipe_pkg::dword_t     ex_mul_tmp1,
    input  dual_pipe_pkg::dword_t     ex_mul_tmp2,
    input  logic                      ex_we_a,
    input  logic                      ex_we_b,
    input  dual_pipe_pkg::reg_addr_t  ex_waddr_a,
    input  dual_pipe_pkg::reg_addr_t  ex_waddr_b,
    input  dual_pipe_pkg::wb_sel_t    ex_sel_b,
    output dual_pipe_pkg::word_t      mem_alu_a,
    output dual_pipe_pkg::word_t      mem_alu_b,
    output dual_pipe_pkg::word_t      mem_pc_b,
    output dual_pipe_pkg::dword_t     mem_mul_tmp1,
    output dual_pipe_pkg::dword_t     mem_mul_tmp2,
    output dual_pipe_pkg::wb_sel_t    mem_sel_b,
    input  dual_pipe_pkg::word_t      mem_wdata_a,  // From mem_result_sel
    input  dual_pipe_pkg::word_t      mem_wdata_b,
    wb_if.producer                    wb_a,
    wb_if.producer                    wb_b
);

    logic                     adv;   // Both stall sources low
    logic                     mem_we_a;
    logic                     mem_we_b;
    dual_pipe_pkg::reg_addr_t mem_waddr_a;
    dual_pipe_pkg::reg_addr_t mem_waddr_b;
    dual_pipe_pkg::word_t     mem_pc_a;

    // A data cache miss or a busy divider freezes every stage
    assign adv = !stall_dcache && !stall_div;

    // EX to MEM
    always_ff @(posedge clk) begin
        if (rst || flush_csr) begin
            mem_alu_a    <= '0;
            mem_alu_b    <= '0;
            mem_pc_a     <= '0;
            mem_pc_b     <= '0;
            mem_mul_tmp1 <= '0;
            mem_mul_tmp2 <= '0;
            mem_sel_b    <= '0;
            mem_we_a     <= 1'b0;
            mem_we_b     <= 1'b0;
            mem_waddr_a  <= '0;
            mem_waddr_b  <= '0;
        end else if (adv) begin
            mem_alu_a   <= ex_alu_a;
            mem_we_a    <= ex_we_a;
            mem_waddr_a <= ex_waddr_a;
            mem_pc_a    <= ex_pc_a;
            mem_waddr_b <= ex_waddr_b;   // Advances even when B is killed
            if (br_a) begin
                // Lane B sits on the wrong path, turn it into a bubble
                mem_alu_b    <= '0;
                mem_we_b     <= 1'b0;
                mem_sel_b    <= '0;
                mem_mul_tmp1 <= '0;
                mem_mul_tmp2 <= '0;
                mem_pc_b     <= '0;
            end else begin
                mem_alu_b    <= ex_alu_b;
                mem_we_b     <= ex_we_b;
                mem_sel_b    <= ex_sel_b;
                mem_mul_tmp1 <= ex_mul_tmp1;
                mem_mul_tmp2 <= ex_mul_tmp2;
                mem_pc_b     <= ex_pc_b;
            end
        end
    end

    // MEM to WB
    always_ff @(posedge clk) begin
        if (rst || flush_csr) begin
            wb_a.we    <= 1'b0;
            wb_a.waddr <= '0;
            wb_a.wdata <= '0;
            wb_a.pc    <= '0;
            wb_b.we    <= 1'b0;
            wb_b.waddr <= '0;
            wb_b.wdata <= '0;
            wb_b.pc    <= '0;
        end else if (adv) begin
            wb_a.we    <= mem_we_a && !exc_a;
            // B is younger, so an exception on A also squashes it
            wb_b.we    <= mem_we_b && !exc_a && !exc_b;
            wb_a.waddr <= mem_waddr_a;
            wb_b.waddr <= mem_waddr_b;
            wb_a.wdata <= mem_wdata_a;
            wb_b.wdata <= mem_wdata_b;
            wb_a.pc    <= mem_pc_a;
            wb_b.pc    <= mem_pc_b;
        end
    end

endmodule

/* hw/wb_if.sv */
// One lane's write-back bundle
interface wb_if;

    logic                    we;
    dual_pipe_pkg::reg_addr_t waddr;
    dual_pipe_pkg::word_t     wdata;
    dual_pipe_pkg::word_t     pc;     // Kept for trace and debug

    modport producer (
        output we,
        output waddr,
        output wdata,
        output pc
    );

    modport consumer (
        input we,
        input waddr,
        input wdata,
        input pc
    );

endinterface

/* hw/dual_pipe_pkg.sv */
`include "dual_pipe_params.svh"

package dual_pipe_pkg;

    // Data word or PC
    typedef logic [`DP_XLEN-1:0] word_t;

    // Multiplier partial result, twice the word width
    typedef logic [2*`DP_XLEN-1:0] dword_t;

    typedef logic [`DP_REG_AW-1:0] reg_addr_t;   // Register number
    typedef logic [`DP_SEL_W-1:0]  wb_sel_t;     // One-hot source select

    // Bit position of each source inside wb_sel_t
    typedef enum logic [2:0] {
        SRC_ALU     = 3'd0,  // ALU result
        SRC_MUL_LO  = 3'd1,  // Low word of multiplier sum
        SRC_MUL_HI  = 3'd2,  // High word of multiplier sum
        SRC_LINK    = 3'd3,  // PC plus 4
        SRC_BYTE_ZX = 3'd4,  // Zero-extended low byte
        SRC_HALF_ZX = 3'd5   // Zero-extended low halfword
    } wb_src_e;

endpackage

/* hw/dual_pipe_params.svh */
`ifndef DUAL_PIPE_PARAMS_SVH
`define DUAL_PIPE_PARAMS_SVH

// Datapath and PC width
`define DP_XLEN   32
// Register file geometry
`define DP_REG_AW 5
`define DP_NREGS  32
// One-hot write-back source select for lane B
`define DP_SEL_W  6

`endif
